/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
TOP       := dram_model_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Finished with errors
PASS_MSG  := Finished with no errors

SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
source/dram_pkg.sv
source/bank_sched_if.sv
source/request_queue.sv
source/command_scheduler.sv
source/bank_fsm.sv
source/line_store.sv
source/read_return.sv
source/dram_model_top.sv
sim/dram_model_asserts.sv
sim/dram_model_tb.sv

/* sim/dram_model_asserts.sv */
// protocol checks on the request port of the sdram model; bound into the top level by the bind below
`timescale 1ns/1ps
`default_nettype none

module dram_model_asserts (
    input logic            itf,
    input logic            reset,
    input logic            read,
    input logic            write,
    input logic            ready,
    input dram_pkg::addr_t addr
);
    import dram_pkg::*;

    logic [1:0] wr_beat;      // beats of the current burst already taken
    addr_t      burst_addr;

    always_ff @(posedge itf) begin
        if (reset) begin
            wr_beat <= '0;
        end else if (write && ready) begin
            wr_beat <= wr_beat + 2'd1;
        end
    end

    always_ff @(posedge itf) begin
        if (write && ready && wr_beat == 2'd0) burst_addr <= addr;
    end

    no_read_and_write: assert property (@(posedge itf) disable iff (reset) !(read && write))
        else $error("read and write high in the same cycle");

    aligned_addr: assert property (@(posedge itf) disable iff (reset)
        (ready && (read || write)) |-> (addr[offset_w-1:0] == '0))
        else $error("accepted address %h has a nonzero offset", addr);

    // remaining beats of a burst keep write, ready and the address
    burst_held: assert property (@(posedge itf) disable iff (reset)
        (wr_beat != 2'd0) |-> (write && ready && addr == burst_addr))
        else $error("write burst interrupted after beat %0d", wr_beat);

endmodule

bind dram_model_top dram_model_asserts u_dram_model_asserts (
    .itf   (itf),
    .reset (reset),
    .read  (read),
    .write (write),
    .ready (ready),
    .addr  (addr)
);

`default_nettype wire

/* sim/dram_model_tb.sv */
// testbench for the sdram timing model; applies a table of writes then reads and checks every beat
`timescale 1ns/1ps
`default_nettype none

module dram_model_tb;
    import dram_pkg::*;

    typedef struct packed {
        logic       is_write;
        addr_t      addr;
        logic [7:0] seed;      // lfsr bits skipped before the write data
    } stim_t;

    logic        itf;
    logic        reset;
    logic        read;
    logic        write;
    addr_t       addr;
    beat_t       wdata;
    logic        ready;
    logic        rvalid;
    addr_t       raddr;
    beat_t       rdata;

    stim_t       stim_q [$];
    line_t       ref_mem [line_addr_t];
    int          pending [addr_t];
    logic [31:0] lfsr_state;
    int          outstanding;
    int          error_count;
    int          check_count;
    int          read_stalls;
    logic        read_seen;

    dram_model_top u_dram_model_top (.*);

    initial begin
        itf = 1'b0;
        forever #20 itf = ~itf;
    end

    function automatic addr_t make_addr(input row_t r, input bank_t b, input logic [1:0] c);
        return {r, b, c, 4'h0};
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic beat_t random_beat();
        beat_t v;
        for (int i = 0; i < bus_w; i++) begin
            v[i] = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic line_t expected_line(input addr_t a);
        line_addr_t l;
        l = a[addr_w-1:offset_w];
        if (ref_mem.exists(l)) return ref_mem[l];
        return '0;   // never written
    endfunction

    task automatic add_entry(input logic w, input addr_t a, input logic [7:0] s);
        stim_t e;
        e.is_write = w;
        e.addr     = a;
        e.seed     = s;
        stim_q.push_back(e);
    endtask

    task automatic build_table();
        // writes over all banks with a second row in banks 0, 1 and 3 and one overwrite
        add_entry(1'b1, make_addr(3'd1, 2'd0, 2'd0), 8'd0);
        add_entry(1'b1, make_addr(3'd1, 2'd0, 2'd1), 8'd5);
        add_entry(1'b1, make_addr(3'd2, 2'd0, 2'd0), 8'd9);
        add_entry(1'b1, make_addr(3'd0, 2'd1, 2'd3), 8'd3);
        add_entry(1'b1, make_addr(3'd5, 2'd2, 2'd2), 8'd17);
        add_entry(1'b1, make_addr(3'd7, 2'd3, 2'd1), 8'd1);
        add_entry(1'b1, make_addr(3'd2, 2'd3, 2'd0), 8'd40);
        add_entry(1'b1, make_addr(3'd3, 2'd1, 2'd0), 8'd7);
        add_entry(1'b1, make_addr(3'd5, 2'd2, 2'd2), 8'd23);
        // reads with hits, misses and lines never written
        add_entry(1'b0, make_addr(3'd1, 2'd0, 2'd0), 8'd0);
        add_entry(1'b0, make_addr(3'd1, 2'd0, 2'd1), 8'd0);
        add_entry(1'b0, make_addr(3'd2, 2'd0, 2'd0), 8'd0);
        add_entry(1'b0, make_addr(3'd0, 2'd1, 2'd3), 8'd0);
        add_entry(1'b0, make_addr(3'd5, 2'd2, 2'd2), 8'd0);
        add_entry(1'b0, make_addr(3'd5, 2'd2, 2'd0), 8'd0);
        add_entry(1'b0, make_addr(3'd7, 2'd3, 2'd1), 8'd0);
        add_entry(1'b0, make_addr(3'd2, 2'd3, 2'd0), 8'd0);
        add_entry(1'b0, make_addr(3'd3, 2'd1, 2'd0), 8'd0);
        add_entry(1'b0, make_addr(3'd6, 2'd1, 2'd1), 8'd0);
        add_entry(1'b0, make_addr(3'd0, 2'd0, 2'd0), 8'd0);
        // ten in a row to bank 0 with alternating rows to fill the queue
        for (int i = 0; i < 10; i++) begin
            logic [1:0] c;
            c = 2'((i / 2) % 4);
            add_entry(1'b0, make_addr(i[0] ? 3'd4 : 3'd1, 2'd0, c), 8'd0);
        end
    endtask

    // returns at the falling edge before the edge that takes the request
    task automatic wait_ready(output int waited);
        waited = 0;
        @(negedge itf);
        while (!ready) begin
            waited++;
            @(negedge itf);
        end
    endtask

    task automatic send_write(input addr_t a, input logic [7:0] seed);
        line_t ln;
        int    waited;
        repeat (seed) lfsr_state = lfsr_step(lfsr_state);
        for (int k = 0; k < burst_len; k++) begin
            ln[k*bus_w +: bus_w] = random_beat();
        end
        for (int k = 0; k < burst_len; k++) begin
            write = 1'b1;
            addr  = a;
            wdata = ln[k*bus_w +: bus_w];
            wait_ready(waited);
            @(posedge itf);
            #2;
        end
        write = 1'b0;
        wdata = '0;
        ref_mem[a[addr_w-1:offset_w]] = ln;
    endtask

    task automatic send_read(input addr_t a);
        int waited;
        read = 1'b1;
        addr = a;
        wait_ready(waited);
        read_stalls += waited;
        @(posedge itf);
        #2;
        read      = 1'b0;
        read_seen = 1'b1;
        if (pending.exists(a)) begin
            pending[a]++;
        end else begin
            pending[a] = 1;
        end
        outstanding++;
    endtask

    // response monitor matching beats to outstanding reads by raddr
    initial begin
        int    beat_n;
        addr_t cur_addr;
        line_t exp_line;
        beat_n   = 0;
        cur_addr = '0;
        exp_line = '0;
        forever begin
            @(negedge itf);
            if (!reset && rvalid) begin
                assert (read_seen) else begin
                    error_count++;
                    $display("rvalid went high before any read was accepted");
                end
                if (beat_n == 0) begin
                    cur_addr = raddr;
                    exp_line = expected_line(raddr);
                    assert (pending.exists(raddr) && pending[raddr] > 0) else begin
                        error_count++;
                        $display("response for address %h that has no outstanding read", raddr);
                    end
                end else begin
                    check_count++;
                    assert (raddr == cur_addr) else begin
                        error_count++;
                        $display("CHECK FAILED raddr: got %h expected %h", raddr, cur_addr);
                    end
                end
                check_count++;
                assert (rdata == exp_line[beat_n*bus_w +: bus_w]) else begin
                    error_count++;
                    $display("CHECK FAILED rdata: addr %h beat %0d got %h expected %h",
                             cur_addr, beat_n, rdata, exp_line[beat_n*bus_w +: bus_w]);
                end
                if (beat_n == burst_len - 1) begin
                    if (pending.exists(cur_addr) && pending[cur_addr] > 0) begin
                        pending[cur_addr]--;
                        outstanding--;
                    end
                    beat_n = 0;
                end else begin
                    beat_n++;
                end
            end else if (!reset) begin
                assert (beat_n == 0) else begin
                    error_count++;
                    $display("rvalid dropped after %0d beats of line %h", beat_n, cur_addr);
                    beat_n = 0;
                end
            end
        end
    end

    initial begin
        int limit;
        #1;
        limit = stim_q.size() * 60 + 500;
        repeat (limit) @(posedge itf);
        $display("timeout after %0d cycles with %0d reads unanswered", limit, outstanding);
        $display("errors: %0d, checks: %0d", error_count, check_count);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        logic read_phase;
        reset       = 1'b1;
        read        = 1'b0;
        write       = 1'b0;
        addr        = '0;
        wdata       = '0;
        lfsr_state  = 32'hf2;
        outstanding = 0;
        error_count = 0;
        check_count = 0;
        read_stalls = 0;
        read_seen   = 1'b0;
        read_phase  = 1'b0;
        build_table();
        repeat (16) @(posedge itf);
        #2;
        reset = 1'b0;
        @(negedge itf);
        check_count += 2;
        assert (ready) else begin
            error_count++;
            $display("CHECK FAILED ready after reset: got %h expected %h", ready, 1'b1);
        end
        assert (!rvalid) else begin
            error_count++;
            $display("CHECK FAILED rvalid after reset: got %h expected %h", rvalid, 1'b0);
        end
        @(posedge itf);
        #2;
        for (int i = 0; i < stim_q.size(); i++) begin
            if (stim_q[i].is_write) begin
                send_write(stim_q[i].addr, stim_q[i].seed);
            end else begin
                if (!read_phase) begin
                    repeat (200) @(posedge itf);   // writes settle before any read
                    #2;
                    read_phase = 1'b1;
                end
                send_read(stim_q[i].addr);
            end
        end
        while (outstanding != 0) @(posedge itf);
        repeat (8) @(negedge itf);
        check_count += 2;
        assert (read_stalls > 0) else begin
            error_count++;
            $display("ready never dropped while reads were waiting");
        end
        assert (!rvalid) else begin
            error_count++;
            $display("CHECK FAILED rvalid when idle: got %h expected %h", rvalid, 1'b0);
        end
        $display("errors: %0d, checks: %0d, ready stalls: %0d",
                 error_count, check_count, read_stalls);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/bank_fsm.sv */
// one bank: precharge, activate and column timing for the request it holds
`timescale 1ns/1ps
`default_nettype none

module bank_fsm #(
    parameter int bank_id = 0
) (
    input  logic            itf,
    input  logic            reset,
    bank_sched_if.bank      bank,
    input  logic            ret_room,
    output logic            done_read,
    output dram_pkg::addr_t done_addr
);
    import dram_pkg::*;

    bank_state_t state;
    row_t        open_row;
    logic        row_open;
    logic        req_read;
    addr_t       req_addr;
    tcount_t     tras;
    tcount_t     trc;
    tcount_t     trp;
    tcount_t     trcd;
    tcount_t     cl;
    tcount_t     wr;
    logic        col_done;

    assign bank.idle[bank_id]     = state == bank_idle;
    assign bank.open_row[bank_id] = open_row;
    assign bank.row_open[bank_id] = row_open;
    assign bank.pre_ok[bank_id]   = (tras == '0) && (trc <= t_rp);
    assign bank.act_req[bank_id]  = (state == bank_pre) && (trp == '0) && (trc == '0);

    // a finished read waits here until the return queue takes it
    assign done_read = (state == bank_col) && req_read && (cl == '0);
    assign done_addr = req_addr;
    assign col_done  = req_read ? (done_read && ret_room) : (wr == '0);

    always_ff @(posedge itf) begin
        if (reset) begin
            state    <= bank_idle;
            open_row <= '0;
            row_open <= 1'b0;
            tras     <= '0;
            trc      <= '0;
            trp      <= '0;
            trcd     <= '0;
            cl       <= '0;
            wr       <= '0;
        end else begin
            if (tras != '0) tras <= tras - 1'b1;
            if (trc != '0)  trc  <= trc - 1'b1;
            if (trp != '0)  trp  <= trp - 1'b1;
            if (trcd != '0) trcd <= trcd - 1'b1;
            if (cl != '0)   cl   <= cl - 1'b1;
            if (wr != '0)   wr   <= wr - 1'b1;
            case (state)
                bank_idle: begin
                    if (bank.issue[bank_id] && bank.issue_hit[bank_id]) begin
                        state <= bank_col;
                        cl    <= tcount_t'(t_cl - 1);
                        wr    <= tcount_t'(t_wr - 1);
                    end else if (bank.issue[bank_id]) begin
                        state    <= bank_pre;
                        row_open <= 1'b0;   // row closes at precharge
                        trp      <= tcount_t'(t_rp - 1);
                    end
                end
                bank_pre: begin
                    if (bank.act_grant[bank_id]) begin
                        state <= bank_act;
                        tras  <= tcount_t'(t_ras);
                        trc   <= tcount_t'(t_rc);
                        trcd  <= tcount_t'(t_rcd - 1);
                    end
                end
                bank_act: begin
                    if (trcd == '0) begin
                        state    <= bank_col;
                        open_row <= get_row(req_addr);
                        row_open <= 1'b1;
                        cl       <= tcount_t'(t_cl - 1);
                        wr       <= tcount_t'(t_wr - 1);
                    end
                end
                default: begin
                    if (col_done) state <= bank_idle;
                end
            endcase
        end
    end

    always_ff @(posedge itf) begin
        if (state == bank_idle && bank.issue[bank_id]) begin
            req_read <= bank.issue_read[bank_id];
            req_addr <= bank.issue_addr[bank_id];
        end
    end

endmodule

`default_nettype wire

/* source/bank_sched_if.sv */
// per-bank handshake between the command scheduler and the bank state machines
`timescale 1ns/1ps
`default_nettype none

interface bank_sched_if;
    import dram_pkg::*;

    logic [num_banks-1:0] idle;
    row_t                 open_row [num_banks];
    logic [num_banks-1:0] row_open;
    logic [num_banks-1:0] pre_ok;     // tRAS done, tRC nearly done
    logic [num_banks-1:0] act_req;
    logic [num_banks-1:0] issue;
    logic [num_banks-1:0] issue_hit;
    logic [num_banks-1:0] act_grant;
    logic [num_banks-1:0] issue_read;
    addr_t                issue_addr [num_banks];

    modport sched (
        input  idle, open_row, row_open, pre_ok, act_req,
        output issue, issue_hit, act_grant, issue_read, issue_addr
    );

    modport bank (
        output idle, open_row, row_open, pre_ok, act_req,
        input  issue, issue_hit, act_grant, issue_read, issue_addr
    );
endinterface

`default_nettype wire

/* source/command_scheduler.sv */
// picks one request per idle bank, row hits first, and arbitrates precharge and activate
`timescale 1ns/1ps
`default_nettype none

module command_scheduler (
    input  logic                                itf,
    input  logic                                reset,
    input  logic [dram_pkg::queue_depth-1:0]    entry_valid,
    input  logic [dram_pkg::queue_depth-1:0]    entry_read,
    input  dram_pkg::addr_t                     entry_addr [dram_pkg::queue_depth],
    input  dram_pkg::line_t                     entry_wdata [dram_pkg::queue_depth],
    output logic [dram_pkg::queue_depth-1:0]    remove,
    output dram_pkg::line_t                     issue_wdata [dram_pkg::num_banks],
    bank_sched_if.sched                         sched
);
    import dram_pkg::*;

    logic [num_banks-1:0] cand_valid;
    logic [num_banks-1:0] cand_hit;
    qidx_t                cand_idx [num_banks];
    logic                 pre_found;
    bank_t                pre_bank;
    qidx_t                pre_idx;
    tcount_t              trrd_cnt;

    always_comb begin
        logic hit;
        pre_found = 1'b0;
        pre_bank  = '0;
        pre_idx   = '0;
        for (int b = 0; b < num_banks; b++) begin
            cand_valid[b] = 1'b0;
            cand_hit[b]   = 1'b0;
            cand_idx[b]   = '0;
            for (int i = 0; i < queue_depth; i++) begin
                hit = sched.row_open[b] && get_row(entry_addr[i]) == sched.open_row[b];
                if (sched.idle[b] && entry_valid[i] && get_bank(entry_addr[i]) == bank_t'(b)) begin
                    // oldest for the bank, unless a younger one hits the open row
                    if (!cand_valid[b] || (!cand_hit[b] && hit)) begin
                        cand_idx[b] = qidx_t'(i);
                        cand_hit[b] = hit;
                    end
                    cand_valid[b] = 1'b1;
                end
            end
            if (cand_valid[b] && !cand_hit[b] && sched.pre_ok[b] && trrd_cnt <= t_rp) begin
                if (!pre_found || cand_idx[b] < pre_idx) begin
                    pre_found = 1'b1;
                    pre_bank  = bank_t'(b);
                    pre_idx   = cand_idx[b];
                end
            end
        end
    end

    always_comb begin
        remove = '0;
        for (int b = 0; b < num_banks; b++) begin
            sched.issue[b] = cand_valid[b]
                           && (cand_hit[b] || (pre_found && pre_bank == bank_t'(b)));
            sched.issue_hit[b]  = cand_hit[b];
            sched.issue_read[b] = entry_read[cand_idx[b]];
            sched.issue_addr[b] = entry_addr[cand_idx[b]];
            issue_wdata[b]      = entry_wdata[cand_idx[b]];
            if (sched.issue[b]) begin
                remove[cand_idx[b]] = 1'b1;
            end
        end
    end

    // lowest requesting bank wins the activate slot
    assign sched.act_grant = (trrd_cnt == '0) ? (sched.act_req & (~sched.act_req + 1'b1)) : '0;

    always_ff @(posedge itf) begin
        if (reset) begin
            trrd_cnt <= '0;
        end else if (sched.act_grant != '0) begin
            trrd_cnt <= tcount_t'(t_rrd);
        end else if (trrd_cnt != '0) begin
            trrd_cnt <= trrd_cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/dram_model_top.sv */
// top of the banked sdram timing model; connects queue, scheduler, banks, storage and return path
`timescale 1ns/1ps
`default_nettype none

module dram_model_top (
    input  logic            itf,
    input  logic            reset,
    input  logic            read,
    input  logic            write,
    input  dram_pkg::addr_t addr,
    input  dram_pkg::beat_t wdata,
    output logic            ready,
    output logic            rvalid,
    output dram_pkg::addr_t raddr,
    output dram_pkg::beat_t rdata
);
    import dram_pkg::*;

    logic [queue_depth-1:0] entry_valid;
    logic [queue_depth-1:0] entry_read;
    logic [queue_depth-1:0] remove;
    addr_t                  entry_addr [queue_depth];
    line_t                  entry_wdata [queue_depth];
    line_t                  issue_wdata [num_banks];
    line_t                  capture [num_banks];
    logic [num_banks-1:0]   done_read;
    logic [num_banks-1:0]   ret_room;
    addr_t                  done_addr [num_banks];

    bank_sched_if bsi ();

    request_queue u_request_queue (
        .itf, .reset, .read, .write, .addr, .wdata, .ready,
        .entry_valid, .entry_read, .entry_addr, .entry_wdata, .remove
    );

    command_scheduler u_command_scheduler (
        .itf, .reset, .entry_valid, .entry_read, .entry_addr, .entry_wdata,
        .remove, .issue_wdata, .sched(bsi.sched)
    );

    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        bank_fsm #(.bank_id(b)) u_bank_fsm (
            .itf,
            .reset,
            .bank      (bsi.bank),
            .ret_room  (ret_room[b]),
            .done_read (done_read[b]),
            .done_addr (done_addr[b])
        );
    end

    line_store u_line_store (
        .itf, .reset,
        .issue      (bsi.issue),
        .issue_read (bsi.issue_read),
        .issue_addr (bsi.issue_addr),
        .issue_wdata,
        .capture
    );

    read_return u_read_return (
        .itf, .reset, .done_read, .done_addr, .capture,
        .room (ret_room),
        .rvalid, .raddr, .rdata
    );

endmodule

`default_nettype wire

/* source/dram_pkg.sv */
// geometry, timing cycle counts and shared types of the sdram model; imported by every block
`default_nettype none

package dram_pkg;

    localparam int bank_w      = 2;
    localparam int row_w       = 3;
    localparam int col_w       = 2;
    localparam int bus_w       = 32;
    localparam int burst_len   = 4;
    localparam int num_banks   = 4;
    localparam int queue_depth = 8;
    localparam int ret_depth   = 8;
    localparam int line_w      = bus_w * burst_len;
    localparam int offset_w    = 4;
    localparam int addr_w      = row_w + bank_w + col_w + offset_w;

    // timings in clock cycles
    localparam int t_cl  = 3;
    localparam int t_rcd = 3;
    localparam int t_rp  = 3;
    localparam int t_ras = 6;
    localparam int t_rc  = 9;
    localparam int t_rrd = 2;
    localparam int t_wr  = 2;

    typedef logic [addr_w-1:0]          addr_t;
    typedef logic [addr_w-offset_w-1:0] line_addr_t;
    typedef logic [bank_w-1:0]          bank_t;
    typedef logic [row_w-1:0]           row_t;
    typedef logic [bus_w-1:0]           beat_t;
    typedef logic [line_w-1:0]          line_t;
    typedef logic [2:0]                 qidx_t;
    typedef logic [3:0]                 tcount_t;

    typedef enum logic [1:0] {
        bank_idle,
        bank_pre,
        bank_act,
        bank_col
    } bank_state_t;

    // field order from bit 0: offset, column, bank, row
    function automatic bank_t get_bank(addr_t a);
        return a[offset_w + col_w +: bank_w];
    endfunction

    function automatic row_t get_row(addr_t a);
        return a[offset_w + col_w + bank_w +: row_w];
    endfunction

    function automatic line_addr_t get_line(addr_t a);
        return a[addr_w-1:offset_w];
    endfunction

endpackage

`default_nettype wire

/* source/line_store.sv */
// line storage, written when a write issues and read into a per-bank capture register
`timescale 1ns/1ps
`default_nettype none

module line_store (
    input  logic                            itf,
    input  logic                            reset,
    input  logic [dram_pkg::num_banks-1:0]  issue,
    input  logic [dram_pkg::num_banks-1:0]  issue_read,
    input  dram_pkg::addr_t                 issue_addr [dram_pkg::num_banks],
    input  dram_pkg::line_t                 issue_wdata [dram_pkg::num_banks],
    output dram_pkg::line_t                 capture [dram_pkg::num_banks]
);
    import dram_pkg::*;

    line_t mem [2**(addr_w - offset_w)];

    always_ff @(posedge itf) begin
        if (reset) begin
            for (int i = 0; i < 2**(addr_w - offset_w); i++) begin
                mem[i] <= '0;
            end
        end else begin
            for (int b = 0; b < num_banks; b++) begin
                if (issue[b] && !issue_read[b]) begin
                    mem[get_line(issue_addr[b])] <= issue_wdata[b];
                end
            end
        end
    end

    // held until the bank hands the read to the return queue
    always_ff @(posedge itf) begin
        for (int b = 0; b < num_banks; b++) begin
            if (issue[b] && issue_read[b]) capture[b] <= mem[get_line(issue_addr[b])];
        end
    end

endmodule

`default_nettype wire

/* source/read_return.sv */
// return queue for finished reads, sent out as four beats tagged with the line address
`timescale 1ns/1ps
`default_nettype none

module read_return (
    input  logic                            itf,
    input  logic                            reset,
    input  logic [dram_pkg::num_banks-1:0]  done_read,
    input  dram_pkg::addr_t                 done_addr [dram_pkg::num_banks],
    input  dram_pkg::line_t                 capture [dram_pkg::num_banks],
    output logic [dram_pkg::num_banks-1:0]  room,
    output logic                            rvalid,
    output dram_pkg::addr_t                 raddr,
    output dram_pkg::beat_t                 rdata
);
    import dram_pkg::*;

    addr_t                      q_addr [ret_depth];
    line_t                      q_line [ret_depth];
    qidx_t                      head;
    qidx_t                      tail;
    logic [$clog2(ret_depth):0] count;
    logic [1:0]                 beat;
    logic                       push;
    logic                       pop;
    bank_t                      sel;

    always_comb begin
        push = 1'b0;
        sel  = '0;
        for (int b = num_banks - 1; b >= 0; b--) begin
            if (done_read[b]) begin
                push = count < ret_depth;
                sel  = bank_t'(b);
            end
        end
        for (int b = 0; b < num_banks; b++) begin
            room[b] = push && sel == bank_t'(b);   // only the accepted bank moves on
        end
    end

    assign rvalid = count != '0;
    assign pop    = rvalid && beat == 2'(burst_len - 1);
    assign raddr  = q_addr[head];
    assign rdata  = q_line[head][beat*bus_w +: bus_w];

    always_ff @(posedge itf) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            beat  <= '0;
        end else begin
            if (push) tail <= tail + 1'b1;
            if (pop)  head <= head + 1'b1;
            if (rvalid) beat <= beat + 2'd1;
            count <= count + push - pop;
        end
    end

    always_ff @(posedge itf) begin
        if (push) begin
            q_addr[tail] <= done_addr[sel];
            q_line[tail] <= capture[sel];
        end
    end

endmodule

`default_nettype wire

/* source/request_queue.sv */
// request queue with write burst assembly and out-of-order removal; feeds the scheduler
`timescale 1ns/1ps
`default_nettype none

module request_queue (
    input  logic                                itf,
    input  logic                                reset,
    input  logic                                read,
    input  logic                                write,
    input  dram_pkg::addr_t                     addr,
    input  dram_pkg::beat_t                     wdata,
    output logic                                ready,
    output logic [dram_pkg::queue_depth-1:0]    entry_valid,
    output logic [dram_pkg::queue_depth-1:0]    entry_read,
    output dram_pkg::addr_t                     entry_addr [dram_pkg::queue_depth],
    output dram_pkg::line_t                     entry_wdata [dram_pkg::queue_depth],
    input  logic [dram_pkg::queue_depth-1:0]    remove
);
    import dram_pkg::*;

    logic [$clog2(queue_depth):0]     count;
    logic [$clog2(queue_depth):0]     count_n;
    logic [1:0]                       beat;
    logic [bus_w*(burst_len-1)-1:0]   wbuf;   // earlier beats, newest on top
    logic                             push;
    logic [queue_depth-1:0]           read_n;
    addr_t                            addr_n [queue_depth];
    line_t                            wdata_n [queue_depth];

    // stay ready for the rest of a burst once it has started
    assign ready = (count < queue_depth) || (beat != 2'd0);
    assign push  = ready && (read || (write && beat == 2'(burst_len - 1)));

    always_comb begin
        for (int i = 0; i < queue_depth; i++) begin
            entry_valid[i] = i < count;
        end
    end

    // compact the survivors in age order, then append
    always_comb begin
        count_n = '0;
        read_n  = entry_read;
        addr_n  = entry_addr;
        wdata_n = entry_wdata;
        for (int i = 0; i < queue_depth; i++) begin
            if (entry_valid[i] && !remove[i]) begin
                read_n[qidx_t'(count_n)]  = entry_read[i];
                addr_n[qidx_t'(count_n)]  = entry_addr[i];
                wdata_n[qidx_t'(count_n)] = entry_wdata[i];
                count_n = count_n + 1'b1;
            end
        end
        if (push) begin
            read_n[qidx_t'(count_n)]  = read;
            addr_n[qidx_t'(count_n)]  = addr;
            wdata_n[qidx_t'(count_n)] = {wdata, wbuf};
            count_n = count_n + 1'b1;
        end
    end

    always_ff @(posedge itf) begin
        if (reset) begin
            count <= '0;
            beat  <= '0;
        end else begin
            count <= count_n;
            if (write && ready) begin
                beat <= beat + 2'd1;   // wraps after the last beat
            end
        end
    end

    always_ff @(posedge itf) begin
        if (write && ready) begin
            wbuf <= {wdata, wbuf[bus_w*(burst_len-1)-1:bus_w]};
        end
        entry_read  <= read_n;
        entry_addr  <= addr_n;
        entry_wdata <= wdata_n;
    end

endmodule

`default_nettype wire
